//--- all.f
+incdir+hw
hw/sram_axil_pkg.sv
hw/axil_slave_ctrl.sv
hw/mem_delay_gen.sv
hw/sram_bank.sv
hw/sram_axil_top.sv
verification/tb_sram_axil.sv

//--- hw/axil_slave_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_axil_params.svh"

module axil_slave_ctrl (
    input  wire                              clk,
    input  wire                              rst,
    // Write address and data, accepted as a pair
    input  wire                              awvalid,
    output logic                             awready,
    input  wire  sram_axil_pkg::axil_aw_t    aw,
    input  wire                              wvalid,
    output logic                             wready,
    input  wire  sram_axil_pkg::axil_w_t     w,
    output logic                             bvalid,
    input  wire                              bready,
    output sram_axil_pkg::axil_b_t           b,
    // Read address and data
    input  wire                              arvalid,
    output logic                             arready,
    input  wire  sram_axil_pkg::axil_ar_t    ar,
    output logic                             rvalid,
    input  wire                              rready,
    output sram_axil_pkg::axil_r_t           r,
    // Bank side
    output logic                             req_valid,
    output sram_axil_pkg::sram_req_t         req,
    output logic                             draw,      // Latency draw, same cycle as req_valid
    input  wire                              rsp_valid,
    input  wire  sram_axil_pkg::sram_rsp_t   rsp
);

    sram_axil_pkg::ctrl_state_e state;
    logic rdy_q;        // Shared ready of AW, W and AR
    logic acc_wr;
    logic acc_rd;

    // Word address inside the array
    function automatic logic in_range(sram_axil_pkg::addr_t a);
        sram_axil_pkg::addr_t word_a;
        word_a = a >> 2;    // Byte offset dropped
        return word_a < sram_axil_pkg::addr_t'(`SRAM_AXIL_DEPTH);
    endfunction

    function automatic sram_axil_pkg::word_idx_t to_idx(sram_axil_pkg::addr_t a);
        return a[2 +: $bits(sram_axil_pkg::word_idx_t)];
    endfunction

    assign awready = rdy_q;
    assign wready  = rdy_q;
    assign arready = rdy_q;

    // Write needs AW and W together and wins over AR
    assign acc_wr = rdy_q && awvalid && wvalid;
    assign acc_rd = rdy_q && arvalid && !(awvalid && wvalid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= sram_axil_pkg::IDLE;
            rdy_q     <= 1'b0;
            req_valid <= 1'b0;
            draw      <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            req_valid <= 1'b0;      // Single-cycle pulses
            draw      <= 1'b0;
            case (state)
                sram_axil_pkg::IDLE: begin
                    rdy_q <= 1'b1;
                    if (acc_wr) begin
                        rdy_q <= 1'b0;
                        if (in_range(aw.addr)) begin
                            state     <= sram_axil_pkg::WRITE;
                            req_valid <= 1'b1;
                            draw      <= 1'b1;
                        end else begin
                            state  <= sram_axil_pkg::RESP;     // Bank skipped
                            bvalid <= 1'b1;
                        end
                    end else if (acc_rd) begin
                        rdy_q <= 1'b0;
                        if (in_range(ar.addr)) begin
                            state     <= sram_axil_pkg::READ;
                            req_valid <= 1'b1;
                            draw      <= 1'b1;
                        end else begin
                            state  <= sram_axil_pkg::RESP;
                            rvalid <= 1'b1;
                        end
                    end
                end
                sram_axil_pkg::WRITE: begin
                    if (rsp_valid) begin
                        state  <= sram_axil_pkg::RESP;
                        bvalid <= 1'b1;
                    end
                end
                sram_axil_pkg::READ: begin
                    if (rsp_valid) begin
                        state  <= sram_axil_pkg::RESP;
                        rvalid <= 1'b1;
                    end
                end
                sram_axil_pkg::RESP: begin
                    // Hold response until the master takes it
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state  <= sram_axil_pkg::IDLE;
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        rdy_q  <= 1'b1;
                    end
                end
                default: state <= sram_axil_pkg::IDLE;
            endcase
        end
    end

    // Request and response payloads
    always_ff @(posedge clk) begin
        if (acc_wr) begin
            req.wr   <= 1'b1;
            req.idx  <= to_idx(aw.addr);
            req.data <= w.data;
            req.strb <= w.strb;
            b.resp   <= in_range(aw.addr) ? sram_axil_pkg::RESP_OKAY
                                          : sram_axil_pkg::RESP_SLVERR;
        end else if (acc_rd) begin
            req.wr   <= 1'b0;
            req.idx  <= to_idx(ar.addr);
            req.data <= '0;
            req.strb <= '0;
            r.data   <= '0;     // Stays zero on SLVERR
            r.resp   <= in_range(ar.addr) ? sram_axil_pkg::RESP_OKAY
                                          : sram_axil_pkg::RESP_SLVERR;
        end
        if (rsp_valid && state == sram_axil_pkg::READ) begin
            r.data <= rsp.data;
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_delay_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_axil_params.svh"

module mem_delay_gen (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   draw,
    output sram_axil_pkg::lat_t   lat     // Valid in the draw cycle
);

    localparam logic [15:0] TAPS = 16'hB400;    // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] SEED = 16'hACE1;    // Any nonzero value

    logic [15:0] lfsr_q;
    sram_axil_pkg::lat_t raw;

    // Galois form, one step per draw
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= SEED;
        end else if (draw) begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? TAPS : 16'h0000);
        end
    end

    assign raw = lfsr_q[$bits(sram_axil_pkg::lat_t)-1:0];
    // Clamp to the configured maximum
    assign lat = (raw > sram_axil_pkg::lat_t'(`SRAM_AXIL_MAX_EXTRA))
               ? sram_axil_pkg::lat_t'(`SRAM_AXIL_MAX_EXTRA) : raw;

endmodule

`default_nettype wire

//--- hw/sram_axil_params.svh
`ifndef SRAM_AXIL_PARAMS_SVH
`define SRAM_AXIL_PARAMS_SVH

// Byte address width of the AXI4-Lite port
`define SRAM_AXIL_ADDR_W 32

// Data bus width, four byte lanes
`define SRAM_AXIL_DATA_W 32

// Number of words in the bank
`define SRAM_AXIL_DEPTH 256

// Largest extra SRAM latency in cycles
// Bank answers in 1 to MAX_EXTRA+1 cycles
`define SRAM_AXIL_MAX_EXTRA 3

`endif

//--- hw/sram_axil_pkg.sv
`default_nettype none

`include "sram_axil_params.svh"

package sram_axil_pkg;

    typedef logic [`SRAM_AXIL_ADDR_W-1:0]                 addr_t;     // Byte address
    typedef logic [`SRAM_AXIL_DATA_W-1:0]                 data_t;
    typedef logic [`SRAM_AXIL_DATA_W/8-1:0]               strb_t;     // One bit per byte lane
    typedef logic [$clog2(`SRAM_AXIL_DEPTH)-1:0]          word_idx_t;
    typedef logic [1:0]                                   resp_t;
    typedef logic [$clog2(`SRAM_AXIL_MAX_EXTRA+1)-1:0]    lat_t;      // Extra latency count

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // AXI4-Lite channel payloads
    typedef struct packed {
        addr_t addr;
    } axil_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        addr_t addr;
    } axil_ar_t;

    typedef struct packed {
        resp_t resp;
    } axil_b_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

    // Controller to bank
    typedef struct packed {
        logic      wr;      // 1 write, 0 read
        word_idx_t idx;
        data_t     data;
        strb_t     strb;
    } sram_req_t;

    typedef struct packed {
        data_t data;
    } sram_rsp_t;

    typedef enum logic [1:0] {IDLE, WRITE, READ, RESP} ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/sram_axil_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_axil_top (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              awvalid,
    output logic                             awready,
    input  wire  sram_axil_pkg::axil_aw_t    aw,
    input  wire                              wvalid,
    output logic                             wready,
    input  wire  sram_axil_pkg::axil_w_t     w,
    output logic                             bvalid,
    input  wire                              bready,
    output sram_axil_pkg::axil_b_t           b,
    input  wire                              arvalid,
    output logic                             arready,
    input  wire  sram_axil_pkg::axil_ar_t    ar,
    output logic                             rvalid,
    input  wire                              rready,
    output sram_axil_pkg::axil_r_t           r
);

    // Controller to bank
    logic                      req_valid;
    sram_axil_pkg::sram_req_t  req;
    logic                      draw;
    sram_axil_pkg::lat_t       lat;
    logic                      rsp_valid;
    sram_axil_pkg::sram_rsp_t  rsp;

    axil_slave_ctrl i_axil_slave_ctrl (
        .clk       (clk),
        .rst       (rst),
        .awvalid   (awvalid),
        .awready   (awready),
        .aw        (aw),
        .wvalid    (wvalid),
        .wready    (wready),
        .w         (w),
        .bvalid    (bvalid),
        .bready    (bready),
        .b         (b),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r),
        .req_valid (req_valid),
        .req       (req),
        .draw      (draw),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    mem_delay_gen i_mem_delay_gen (
        .clk  (clk),
        .rst  (rst),
        .draw (draw),
        .lat  (lat)
    );

    sram_bank i_sram_bank (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .lat       (lat),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

//--- hw/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_axil_params.svh"

module sram_bank (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              req_valid,
    input  wire  sram_axil_pkg::sram_req_t   req,
    input  wire  sram_axil_pkg::lat_t        lat,
    output logic                             rsp_valid,
    output sram_axil_pkg::sram_rsp_t         rsp
);

    sram_axil_pkg::data_t mem [`SRAM_AXIL_DEPTH];   // Storage array

    sram_axil_pkg::sram_req_t pend_q;   // Request waiting out its latency
    sram_axil_pkg::sram_req_t cur;
    sram_axil_pkg::lat_t      cnt_q;    // Cycles left after this one
    logic                     busy_q;
    logic                     fire;     // Access happens at this edge

    // Zero latency serves the request straight from the port
    assign cur  = req_valid ? req : pend_q;
    assign fire = req_valid ? (lat == '0) : (busy_q && cnt_q == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fire;      // One pulse per request
            if (req_valid) begin
                busy_q <= (lat != '0);
                if (lat != '0) begin
                    cnt_q <= lat - 1'b1;
                end
            end else if (busy_q) begin
                if (cnt_q == '0) begin
                    busy_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            pend_q <= req;
        end
        if (fire) begin
            if (cur.wr) begin
                for (int i = 0; i < $bits(sram_axil_pkg::strb_t); i++) begin
                    if (cur.strb[i]) begin
                        mem[cur.idx][8*i +: 8] <= cur.data[8*i +: 8];   // Byte lane i
                    end
                end
            end
            rsp.data <= mem[cur.idx];   // Word as it stands at this edge
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_sram_axil.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_axil_params.svh"

module tb_sram_axil;

    logic clk = 1'b0;
    logic rst;
    logic awvalid, wvalid, arvalid, bready, rready;
    logic awready, wready, arready, bvalid, rvalid;
    sram_axil_pkg::axil_aw_t aw;
    sram_axil_pkg::axil_w_t  w;
    sram_axil_pkg::axil_ar_t ar;
    sram_axil_pkg::axil_b_t  b;
    sram_axil_pkg::axil_r_t  r;

    sram_axil_pkg::data_t ref_mem [`SRAM_AXIL_DEPTH];  // Expected bank contents
    logic [31:0] rng = 32'h7d69;
    int errors = 0;
    int passes = 0;
    int err_mark;       // Error count when the current test began
    string test_name;

    sram_axil_top i_sram_axil_top (.*);

    always #10 clk = ~clk;     // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Valid addresses lie below DEPTH words of four bytes
    function automatic bit in_range(input sram_axil_pkg::addr_t a);
        return a < 32'(4 * `SRAM_AXIL_DEPTH);
    endfunction

    // Strobed bytes come from the new word and the rest stay
    function automatic sram_axil_pkg::data_t merge_bytes(input sram_axil_pkg::data_t old,
            input sram_axil_pkg::data_t nw, input sram_axil_pkg::strb_t strb);
        sram_axil_pkg::data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = nw[8*i +: 8];
        end
        return res;
    endfunction

    task automatic check_data(input sram_axil_pkg::data_t exp, input sram_axil_pkg::data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected data %h, actual %h", test_name, exp, act);
            errors++;
        end else
            passes++;
    endtask

    task automatic check_resp(input sram_axil_pkg::resp_t exp, input sram_axil_pkg::resp_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected resp %b, actual %b", test_name, exp, act);
            errors++;
        end else
            passes++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic report_test();
        $display("Test %s finished with %0d errors", test_name, errors - err_mark);
    endtask

    // Transfer happens at the rising edge after a ready is seen
    task automatic wait_accept(input bit is_wr, output bit ok);
        int cnt;
        cnt = 0;
        while (!(is_wr ? (awready && wready) : arready) && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        ok = is_wr ? (awready && wready) : arready;
        if (!ok) begin
            if (is_wr)
                report_error("write address and data not accepted within 50 cycles");
            else
                report_error("read address not accepted within 50 cycles");
        end
        @(negedge clk);
        if (is_wr) begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end else
            arvalid = 1'b0;
    endtask

    // Write response with bready held low for hold cycles
    task automatic take_b(input int hold, output sram_axil_pkg::resp_t resp);
        int cnt;
        sram_axil_pkg::axil_b_t first;
        cnt = 0;
        while (!bvalid && cnt < 50) begin
            if (rvalid)
                report_error("read response came before the write response");
            @(negedge clk);
            cnt++;
        end
        resp = b.resp;
        if (!bvalid) begin
            report_error("no write response within 50 cycles");
            return;
        end
        first = b;
        repeat (hold) begin
            @(negedge clk);
            if (!bvalid || awready || wready || arready)
                report_error("bvalid dropped or a ready rose while bready was low");
            check_resp(first.resp, b.resp);     // Payload must stay put
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic take_r(input int hold, output sram_axil_pkg::axil_r_t rsp);
        int cnt;
        sram_axil_pkg::axil_r_t first;
        cnt = 0;
        while (!rvalid && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        rsp = r;
        if (!rvalid) begin
            report_error("no read response within 50 cycles");
            return;
        end
        first = r;
        repeat (hold) begin
            @(negedge clk);
            if (!rvalid || awready || wready || arready)
                report_error("rvalid dropped or a ready rose while rready was low");
            check_data(first.data, r.data);
            check_resp(first.resp, r.resp);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axil_write(input sram_axil_pkg::addr_t addr, input sram_axil_pkg::data_t data,
            input sram_axil_pkg::strb_t strb, input int hold, output sram_axil_pkg::resp_t resp);
        bit ok;
        resp = 'x;
        @(negedge clk);
        aw.addr = addr;
        w.data  = data;
        w.strb  = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_accept(1'b1, ok);
        if (ok)
            take_b(hold, resp);
    endtask

    task automatic axil_read(input sram_axil_pkg::addr_t addr, input int hold,
            output sram_axil_pkg::axil_r_t rsp);
        bit ok;
        rsp = 'x;
        @(negedge clk);
        ar.addr = addr;
        arvalid = 1'b1;
        wait_accept(1'b0, ok);
        if (ok)
            take_r(hold, rsp);
    endtask

    // Expected response from the range rule and model updated on OKAY
    task automatic write_and_check(input sram_axil_pkg::addr_t addr,
            input sram_axil_pkg::data_t data, input sram_axil_pkg::strb_t strb, input int hold);
        sram_axil_pkg::resp_t resp;
        axil_write(addr, data, strb, hold, resp);
        if (in_range(addr)) begin
            check_resp(sram_axil_pkg::RESP_OKAY, resp);
            ref_mem[addr >> 2] = merge_bytes(ref_mem[addr >> 2], data, strb);
        end else
            check_resp(sram_axil_pkg::RESP_SLVERR, resp);
    endtask

    task automatic read_and_check(input sram_axil_pkg::addr_t addr, input int hold);
        sram_axil_pkg::axil_r_t rsp;
        axil_read(addr, hold, rsp);
        if (in_range(addr)) begin
            check_resp(sram_axil_pkg::RESP_OKAY, rsp.resp);
            check_data(ref_mem[addr >> 2], rsp.data);
        end else begin
            check_resp(sram_axil_pkg::RESP_SLVERR, rsp.resp);
            check_data('0, rsp.data);      // SLVERR reads return zero
        end
    endtask

    // Known contents everywhere with a pattern from the whole index
    task automatic fill_memory();
        begin_test("fill_memory");
        for (int i = 0; i < `SRAM_AXIL_DEPTH; i++)
            write_and_check(32'(i) * 4, (32'(i) * 32'h9E37_79B1) ^ 32'hC3A5_0000, 4'hF, 0);
        report_test();
    endtask

    task automatic basic_write_read();
        sram_axil_pkg::addr_t addrs[$];
        begin_test("basic_write_read");
        repeat (8) begin
            rng = xorshift32(rng);
            addrs.push_back((rng % `SRAM_AXIL_DEPTH) * 4);
            write_and_check(addrs[$], xorshift32(rng), 4'hF, 0);
        end
        foreach (addrs[i])
            read_and_check(addrs[i], 0);
        report_test();
    endtask

    task automatic byte_strobes();
        sram_axil_pkg::addr_t addr;
        begin_test("byte_strobes");
        for (int s = 1; s < 15; s++) begin     // Every partial strobe
            rng  = xorshift32(rng);
            addr = (rng % `SRAM_AXIL_DEPTH) * 4;
            write_and_check(addr, xorshift32(rng), 4'hF, 0);
            rng  = xorshift32(rng);
            write_and_check(addr, rng, 4'(s), 0);
            read_and_check(addr, 0);
        end
        report_test();
    endtask

    task automatic out_of_range();
        sram_axil_pkg::addr_t bad[3];
        begin_test("out_of_range");
        bad[0] = 4 * `SRAM_AXIL_DEPTH;         // Would alias word 0 if the check failed
        bad[1] = 4 * `SRAM_AXIL_DEPTH + 32'h105;
        bad[2] = 32'hFFFF_FFFC;
        foreach (bad[i]) begin
            write_and_check(bad[i], 32'hDEAD_BEEF, 4'hF, 0);
            read_and_check(bad[i], 0);
        end
        read_and_check(0, 0);
        read_and_check(32'h104, 0);
        read_and_check(4 * (`SRAM_AXIL_DEPTH - 1), 0);
        report_test();
    endtask

    task automatic back_pressure();
        sram_axil_pkg::addr_t addr;
        begin_test("back_pressure");
        repeat (10) begin
            rng  = xorshift32(rng);
            addr = ((rng >> 4) % `SRAM_AXIL_DEPTH) * 4;
            write_and_check(addr, xorshift32(rng), 4'hF, rng % 11);
            rng  = xorshift32(rng);
            read_and_check(addr, rng % 11);
        end
        report_test();
    endtask

    // AW, W and AR valid together and the write must go first
    task automatic write_priority();
        sram_axil_pkg::addr_t   addr;
        sram_axil_pkg::resp_t   resp;
        sram_axil_pkg::axil_r_t rsp;
        bit ok;
        begin_test("write_priority");
        rng  = xorshift32(rng);
        addr = (rng % `SRAM_AXIL_DEPTH) * 4;
        rng  = xorshift32(rng);
        resp = 'x;
        rsp  = 'x;
        @(negedge clk);
        aw.addr = addr;
        ar.addr = addr;
        w.data  = rng;
        w.strb  = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        arvalid = 1'b1;
        wait_accept(1'b1, ok);
        if (ok)
            take_b(0, resp);
        check_resp(sram_axil_pkg::RESP_OKAY, resp);
        ref_mem[addr >> 2] = rng;
        wait_accept(1'b0, ok);                  // AR still pending
        if (ok)
            take_r(0, rsp);
        check_resp(sram_axil_pkg::RESP_OKAY, rsp.resp);
        check_data(rng, rsp.data);
        report_test();
    endtask

    task automatic aw_waits_for_w();
        sram_axil_pkg::addr_t addr;
        sram_axil_pkg::resp_t resp;
        bit ok;
        begin_test("aw_waits_for_w");
        rng  = xorshift32(rng);
        addr = (rng % `SRAM_AXIL_DEPTH) * 4;
        resp = 'x;
        @(negedge clk);
        aw.addr = addr;
        w.data  = 32'h0BAD_F00D;
        w.strb  = 4'hF;
        awvalid = 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (!awready || bvalid)
                report_error("write address accepted without write data");
        end
        wvalid = 1'b1;
        wait_accept(1'b1, ok);
        if (ok)
            take_b(0, resp);
        check_resp(sram_axil_pkg::RESP_OKAY, resp);
        ref_mem[addr >> 2] = 32'h0BAD_F00D;
        read_and_check(addr, 0);
        report_test();
    endtask

    task automatic random_traffic();
        sram_axil_pkg::addr_t addr;
        int hold;
        begin_test("random_traffic");
        repeat (200) begin
            rng  = xorshift32(rng);
            addr = ((rng >> 8) % (`SRAM_AXIL_DEPTH + 8)) * 4 + rng[1:0];  // Low bits ignored
            hold = (rng >> 24) % 4;
            if (rng[2]) begin
                rng = xorshift32(rng);
                write_and_check(addr, rng, rng[31:28], hold);
            end else
                read_and_check(addr, hold);
        end
        report_test();
    endtask

    initial begin
        rst     = 1'b1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        bready  = 1'b0;
        rready  = 1'b0;
        aw      = '0;
        w       = '0;
        ar      = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        fill_memory();
        basic_write_read();
        byte_strobes();
        out_of_range();
        back_pressure();
        write_priority();
        aw_waits_for_w();
        random_traffic();
        $display("Checks passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
